// ==== hw/chan_param_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module chan_param_table import sa_quant_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cfg_we,
  input  logic [3:0]              cfg_addr,
  input  logic [scale_w-1:0]      cfg_scale,
  input  logic signed [acc_w-1:0] cfg_bias,
  input  logic [row_idx_w-1:0]    out_sa_row_idx,
  output logic [scale_w-1:0]      row_scale,
  output logic signed [acc_w-1:0] row_bias
);

  logic [scale_w-1:0]      scale_q [num_rows];
  logic signed [acc_w-1:0] bias_q [num_rows];
  logic [3:0]              rd_idx;

  // host writes, only between tiles
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_rows; i++) begin
        scale_q[i] <= scale_w'(1) << quant_shift;   // unity gain
        bias_q[i]  <= '0;
      end
    end else if (cfg_we) begin
      scale_q[cfg_addr] <= cfg_scale;
      bias_q[cfg_addr]  <= cfg_bias;
    end
  end

  assign rd_idx = out_sa_row_idx[3:0];

  // scale used in stage 1
  assign row_scale = scale_q[rd_idx];

  // bias lines up with stage 2
  always_ff @(posedge clk) begin
    row_bias <= bias_q[rd_idx];
  end

endmodule

`default_nettype wire

// ==== hw/post_quant_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module post_quant_pipe import sa_quant_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic signed [acc_w-1:0] sa_sum,
  input  logic [scale_w-1:0]      row_scale,
  input  logic signed [acc_w-1:0] row_bias,
  input  post_mode_e              post_mode,
  input  logic                    channel_out_en,
  input  logic [row_idx_w-1:0]    out_sa_row_idx,
  input  logic                    product_add_bias_reset,
  output logic                    quant_valid,
  output logic [3:0]              quant_ch,
  output logic [7:0]              quant_data
);

  logic signed [acc_w+scale_w-1:0] prod;     // 48 bit
  logic signed [acc_w+scale_w-1:0] s1_val;
  logic signed [acc_w+scale_w-1:0] s2_val;
  logic                            s1_vld;
  logic                            s2_vld;
  logic [3:0]                      s1_ch;
  logic [3:0]                      s2_ch;

  //////////////////////////////////////////////////
  // valid flag through the three stages
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || product_add_bias_reset) begin
      s1_vld      <= 1'b0;
      s2_vld      <= 1'b0;
      quant_valid <= 1'b0;
    end else begin
      s1_vld      <= channel_out_en;
      s2_vld      <= s1_vld;
      quant_valid <= s2_vld;
    end
  end

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////

  // scale is unsigned, keep it positive
  assign prod = sa_sum * $signed({1'b0, row_scale});

  // stage 1, multiply by E
  always_ff @(posedge clk) begin
    if (post_mode == pm_scaled) begin
      s1_val <= prod >>> quant_shift;
    end else begin
      s1_val <= (acc_w+scale_w)'(sa_sum);   // raw pass
    end
    s1_ch <= out_sa_row_idx[3:0];
  end

  // stage 2, bias
  always_ff @(posedge clk) begin
    s2_val <= s1_val + row_bias;
    s2_ch  <= s1_ch;
  end

  // stage 3, relu and 8 bit clip
  always_ff @(posedge clk) begin
    if (s2_val < 0) begin
      quant_data <= 8'd0;
    end else if (s2_val > 255) begin
      quant_data <= 8'hff;
    end else begin
      quant_data <= s2_val[7:0];
    end
    quant_ch <= s2_ch;
  end

  // one burst per tile, one word per channel
  assert property (@(posedge clk) disable iff (reset)
    quant_valid [*num_rows] |=> !quant_valid);

endmodule

`default_nettype wire

// ==== hw/sa_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_array import sa_quant_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       sa_en,
  input  logic                       sa_reset,
  input  logic                       channel_out_reset,
  input  logic signed [data_w-1:0]   fm_data,
  input  logic [num_rows*data_w-1:0] wt_row,
  input  logic [row_idx_w-1:0]       out_sa_row_idx,
  output logic signed [acc_w-1:0]    sa_sum
);

  logic signed [data_w-1:0] fm_q [num_rows];    // fm skew chain
  logic [num_rows-2:0]      en_q;
  logic [num_rows-2:0]      clr_q;
  logic [num_rows-1:0]      en_sk;              // enable seen by each row
  logic [num_rows-1:0]      clr_sk;
  logic signed [acc_w-1:0]  row_sum [num_rows];

  assign en_sk  = {en_q, sa_en};
  assign clr_sk = {clr_q, channel_out_reset};

  // control skew, one cycle per row
  always_ff @(posedge clk) begin
    if (reset || sa_reset) begin
      en_q  <= '0;
      clr_q <= '0;
    end else begin
      en_q  <= en_sk[num_rows-2:0];
      clr_q <= clr_sk[num_rows-2:0];
    end
  end

  always_ff @(posedge clk) begin
    fm_q[0] <= fm_data;
    for (int i = 1; i < num_rows; i++) begin
      fm_q[i] <= fm_q[i-1];
    end
  end

  for (genvar r = 0; r < num_rows; r++) begin : g_row
    logic signed [data_w-1:0]   wt_q [r+1];   // lane r delayed r+1 cycles
    logic signed [2*data_w-1:0] prod;
    logic signed [acc_w-1:0]    acc;

    always_ff @(posedge clk) begin
      wt_q[0] <= wt_row[r*data_w +: data_w];
      for (int i = 1; i <= r; i++) begin
        wt_q[i] <= wt_q[i-1];
      end
    end

    assign prod = fm_q[r] * wt_q[r];

    always_ff @(posedge clk) begin
      if (clr_sk[r]) begin
        acc <= en_sk[r] ? acc_w'(prod) : '0;   // first word restarts the sum
      end else if (en_sk[r]) begin
        acc <= acc + acc_w'(prod);
      end
    end

    assign row_sum[r] = acc;
  end

  assign sa_sum = row_sum[out_sa_row_idx[$clog2(num_rows)-1:0]];

  // sequencer index must stay inside the array
  assert property (@(posedge clk) disable iff (reset)
    out_sa_row_idx < row_idx_w'(num_rows));

endmodule

`default_nettype wire

// ==== hw/sa_quant_pkg.sv ====
`default_nettype none

package sa_quant_pkg;

  // array geometry
  localparam int num_rows = 16;     // one output channel per row
  localparam int acc_w    = 32;
  localparam int data_w   = 8;      // fm value and weight, signed

  // post-processing
  localparam int scale_w     = 16;  // scale E, unsigned
  localparam int quant_shift = 8;   // scale 256 is unity

  // sequencer counts
  localparam int row_idx_w = 6;
  localparam logic [row_idx_w-1:0] drain_last    = 6'd32;
  localparam logic [row_idx_w-1:0] readout_first = 6'd16;

  // result path opcode, unknown codes fall back to raw
  typedef enum logic [3:0] {
    pm_raw    = 4'd0,
    pm_scaled = 4'd1
  } post_mode_e;

endpackage

`default_nettype wire

// ==== hw/sa_quant_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_quant_top import sa_quant_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       re_fm_en,
  input  logic [3:0]                 mode,
  input  logic [31:0]                nif_mult_k_mult_k,
  input  logic signed [data_w-1:0]   fm_data,
  input  logic [num_rows*data_w-1:0] wt_row,
  input  logic                       cfg_we,
  input  logic [3:0]                 cfg_addr,
  input  logic [scale_w-1:0]         cfg_scale,
  input  logic signed [acc_w-1:0]    cfg_bias,
  output logic                       quant_valid,
  output logic [3:0]                 quant_ch,
  output logic [7:0]                 quant_data,
  output logic                       tile_done
);

  logic                    sa_en;
  logic                    sa_reset;
  logic                    channel_out_reset;
  logic                    channel_out_en;
  logic [row_idx_w-1:0]    out_sa_row_idx;
  post_mode_e              post_mode;
  logic                    product_add_bias_reset;
  logic signed [acc_w-1:0] sa_sum;
  logic [scale_w-1:0]      row_scale;
  logic signed [acc_w-1:0] row_bias;

  sa_tile_seq sa_tile_seq_i (
    .clk                    (clk),
    .reset                  (reset),
    .re_fm_en               (re_fm_en),
    .mode                   (mode),
    .nif_mult_k_mult_k      (nif_mult_k_mult_k),
    .sa_en                  (sa_en),
    .sa_reset               (sa_reset),
    .channel_out_reset      (channel_out_reset),
    .channel_out_en         (channel_out_en),
    .out_sa_row_idx         (out_sa_row_idx),
    .post_mode              (post_mode),
    .product_add_bias_en    (),
    .product_add_bias_reset (product_add_bias_reset),
    .relu_scale_en          (),
    .relu_scale_add_end     (tile_done)
  );

  sa_array sa_array_i (
    .clk               (clk),
    .reset             (reset),
    .sa_en             (sa_en),
    .sa_reset          (sa_reset),
    .channel_out_reset (channel_out_reset),
    .fm_data           (fm_data),
    .wt_row            (wt_row),
    .out_sa_row_idx    (out_sa_row_idx),
    .sa_sum            (sa_sum)
  );

  chan_param_table chan_param_table_i (
    .clk            (clk),
    .reset          (reset),
    .cfg_we         (cfg_we),
    .cfg_addr       (cfg_addr),
    .cfg_scale      (cfg_scale),
    .cfg_bias       (cfg_bias),
    .out_sa_row_idx (out_sa_row_idx),
    .row_scale      (row_scale),
    .row_bias       (row_bias)
  );

  post_quant_pipe post_quant_pipe_i (
    .clk                    (clk),
    .reset                  (reset),
    .sa_sum                 (sa_sum),
    .row_scale              (row_scale),
    .row_bias               (row_bias),
    .post_mode              (post_mode),
    .channel_out_en         (channel_out_en),
    .out_sa_row_idx         (out_sa_row_idx),
    .product_add_bias_reset (product_add_bias_reset),
    .quant_valid            (quant_valid),
    .quant_ch               (quant_ch),
    .quant_data             (quant_data)
  );

endmodule

`default_nettype wire

// ==== hw/sa_tile_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module sa_tile_seq import sa_quant_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 re_fm_en,
  input  logic [3:0]           mode,
  input  logic [31:0]          nif_mult_k_mult_k,
  output logic                 sa_en,
  output logic                 sa_reset,
  output logic                 channel_out_reset,
  output logic                 channel_out_en,
  output logic [row_idx_w-1:0] out_sa_row_idx,
  output post_mode_e           post_mode,
  output logic                 product_add_bias_en,
  output logic                 product_add_bias_reset,
  output logic                 relu_scale_en,
  output logic                 relu_scale_add_end
);

  logic                 pix_run;
  logic [15:0]          pix_cnt;
  logic                 pix_active;
  logic                 pix_last;    // last input word of the tile
  logic                 drn_run;
  logic [row_idx_w-1:0] drn_cnt;
  logic                 drn_active;
  logic                 drn_last;
  logic [1:0]           end_q;       // tile end through the result stages
  logic                 tile_busy;

  //////////////////////////////////////////////////
  // pixel and drain counters
  //////////////////////////////////////////////////

  assign pix_active = re_fm_en || pix_run;
  assign pix_last   = pix_active && ({16'd0, pix_cnt} == nif_mult_k_mult_k);
  assign drn_active = pix_last || drn_run;   // drain starts on the last word
  assign drn_last   = drn_active && (drn_cnt == drain_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_run <= 1'b0;
      pix_cnt <= '0;
    end else if (pix_active) begin
      pix_run <= !pix_last;
      pix_cnt <= pix_last ? '0 : pix_cnt + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      drn_run <= 1'b0;
      drn_cnt <= '0;
    end else if (drn_active) begin
      drn_run <= !drn_last;
      drn_cnt <= drn_last ? '0 : drn_cnt + row_idx_w'(1);
    end
  end

  //////////////////////////////////////////////////
  // enables and end pulses
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      sa_en                  <= 1'b0;
      sa_reset               <= 1'b0;
      channel_out_reset      <= 1'b0;
      channel_out_en         <= 1'b0;
      product_add_bias_en    <= 1'b0;
      product_add_bias_reset <= 1'b0;
      relu_scale_en          <= 1'b0;
      end_q                  <= '0;
      relu_scale_add_end     <= 1'b0;
      tile_busy              <= 1'b0;
    end else begin
      sa_en                  <= pix_active;          // word sits in array input reg
      channel_out_reset      <= re_fm_en;            // clears acc with the first word
      sa_reset               <= drn_last;            // flush skew chain
      product_add_bias_reset <= channel_out_reset;   // result pipe empty before readout
      if (drn_last) begin
        channel_out_en <= 1'b0;
      end else if (drn_active && (drn_cnt == readout_first)) begin
        channel_out_en <= 1'b1;
      end
      product_add_bias_en <= channel_out_en;
      relu_scale_en       <= product_add_bias_en;
      end_q               <= {end_q[0], sa_reset};
      relu_scale_add_end  <= end_q[1];
      if (re_fm_en) begin
        tile_busy <= 1'b1;
      end else if (relu_scale_add_end) begin
        tile_busy <= 1'b0;
      end
    end
  end

  // channel 0 at drain count 17
  assign out_sa_row_idx = channel_out_en ? drn_cnt - readout_first - row_idx_w'(1) : '0;
  assign post_mode      = (mode == pm_scaled) ? pm_scaled : pm_raw;

  // no restart until the previous tile has signalled done
  assert property (@(posedge clk) disable iff (reset)
    re_fm_en |-> (!tile_busy || relu_scale_add_end));

  assert property (@(posedge clk) disable iff (reset) !(sa_en && channel_out_en));

endmodule

`default_nettype wire

// ==== sa_quant.f ====
hw/sa_quant_pkg.sv
hw/sa_tile_seq.sv
hw/sa_array.sv
hw/chan_param_table.sv
hw/post_quant_pipe.sv
hw/sa_quant_top.sv
test/tb_sa_quant.sv

// ==== test/tb_sa_quant.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sa_quant
  import sa_quant_pkg::*;
();

  localparam int max_words      = 64;
  localparam int timeout_cycles = 200;   // well above the n + 36 cycles of a tile

  logic                       clk;
  logic                       reset;
  logic                       re_fm_en;
  logic [3:0]                 mode;
  logic [31:0]                nif_mult_k_mult_k;
  logic signed [data_w-1:0]   fm_data;
  logic [num_rows*data_w-1:0] wt_row;
  logic                       cfg_we;
  logic [3:0]                 cfg_addr;
  logic [scale_w-1:0]         cfg_scale;
  logic signed [acc_w-1:0]    cfg_bias;
  logic                       quant_valid;
  logic [3:0]                 quant_ch;
  logic [7:0]                 quant_data;
  logic                       tile_done;

  logic signed [data_w-1:0] fm_mem [max_words];
  logic signed [data_w-1:0] wt_mem [max_words][num_rows];
  int                       scale_tab [num_rows];
  int                       bias_tab [num_rows];
  int                       errors;
  int                       checks;
  int                       tests_run;
  bit                       hung;        // a tile never ended

  sa_quant_top sa_quant_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers and reference model
  //////////////////////////////////////////////////

  // outputs are settled and inputs may change here
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report(input string name, input int err_before);
    tests_run++;
    $display("test %s: %s, %0d errors", name, (errors == err_before) ? "ok" : "mismatch",
             errors - err_before);
  endtask

  function automatic int channel_sum(input int ch, input int n);
    int sum;
    sum = 0;
    for (int k = 0; k <= n; k++) begin
      sum += int'(fm_mem[k]) * int'(wt_mem[k][ch]);
    end
    return sum;
  endfunction

  // scale, bias, relu, clip to 8 bits
  function automatic logic [7:0] quantize(input int sum, input int ch, input bit scaled);
    longint val;
    if (scaled) begin
      val = (longint'(sum) * longint'(scale_tab[ch])) >>> quant_shift;
    end else begin
      val = longint'(sum);
    end
    val += longint'(bias_tab[ch]);
    if (val < 0) begin
      return 8'd0;
    end
    if (val > 255) begin
      return 8'hff;
    end
    return val[7:0];
  endfunction

  task automatic fill_random(input int fm_lo, fm_hi, wt_lo, wt_hi);
    for (int k = 0; k < max_words; k++) begin
      fm_mem[k] = data_w'(fm_lo + int'($urandom_range(fm_hi - fm_lo)));
      for (int ch = 0; ch < num_rows; ch++) begin
        wt_mem[k][ch] = data_w'(wt_lo + int'($urandom_range(wt_hi - wt_lo)));
      end
    end
  endtask

  task automatic set_params(input int scale, input int bias);
    for (int ch = 0; ch < num_rows; ch++) begin
      scale_tab[ch] = scale;
      bias_tab[ch]  = bias;
    end
  endtask

  task automatic load_params();
    for (int ch = 0; ch < num_rows; ch++) begin
      cfg_we    = 1'b1;
      cfg_addr  = 4'(ch);
      cfg_scale = scale_w'(scale_tab[ch]);
      cfg_bias  = acc_w'(bias_tab[ch]);
      tick();
    end
    cfg_we = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // one tile through the DUT and back
  //////////////////////////////////////////////////

  task automatic run_tile(input int n, input logic [3:0] code);
    logic [7:0] exp_data [num_rows];
    int         got_cnt;
    int         done_cnt;
    int         wait_cnt;
    bit         run_ended;
    for (int ch = 0; ch < num_rows; ch++) begin
      exp_data[ch] = quantize(channel_sum(ch, n), ch, code == 4'd1);
    end
    mode              = code;
    nif_mult_k_mult_k = n;
    for (int k = 0; k <= n + 1; k++) begin   // word n+1 is a stray one
      re_fm_en = (k == 0);
      fm_data  = fm_mem[k];
      for (int ch = 0; ch < num_rows; ch++) begin
        wt_row[ch*data_w +: data_w] = wt_mem[k][ch];
      end
      tick();
    end
    fm_data   = '0;
    wt_row    = '0;
    got_cnt   = 0;
    done_cnt  = 0;
    wait_cnt  = 0;
    run_ended = 1'b0;
    while (done_cnt == 0 && wait_cnt < timeout_cycles) begin
      if (quant_valid) begin
        if (run_ended || got_cnt >= num_rows) begin
          errors++;
          $display("quant_valid was high outside one run of 16 results at %0t", $time);
        end else begin
          check_value("quant_ch", quant_ch, got_cnt);
          check_value("quant_data", quant_data, exp_data[got_cnt]);
        end
        got_cnt++;
      end else if (got_cnt > 0) begin
        run_ended = 1'b1;
      end
      if (tile_done) begin
        done_cnt++;
        if (quant_valid || got_cnt != num_rows) begin
          errors++;
          $display("tile_done came before the last result at %0t", $time);
        end
      end
      tick();
      wait_cnt++;
    end
    if (done_cnt == 0) begin
      errors++;
      hung = 1'b1;
      $display("timeout, tile_done did not arrive within %0d cycles", timeout_cycles);
      return;
    end
    check_value("result count", got_cnt, num_rows);
    for (int i = 0; i < 4; i++) begin
      if (tile_done || quant_valid) begin
        errors++;
        $display("extra tile_done or quant_valid after the tile ended at %0t", $time);
      end
      tick();
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_raw_unity();
    int err0;
    err0 = errors;
    set_params(256, 0);
    load_params();
    fill_random(0, 5, 0, 5);   // sums stay below 255
    run_tile(7, 4'd0);
    report("raw_unity", err0);
  endtask

  task automatic test_scaled_random();
    int err0;
    err0 = errors;
    for (int ch = 0; ch < num_rows; ch++) begin
      scale_tab[ch] = int'($urandom_range(700, 64));
      bias_tab[ch]  = int'($urandom_range(400)) - 200;
    end
    load_params();
    fill_random(0, 15, -8, 15);
    run_tile(11, 4'd1);
    report("scaled_random", err0);
  endtask

  task automatic test_clip_saturate();
    int err0;
    err0 = errors;
    set_params(0, 0);   // a scaled run would give only zeros
    load_params();
    fill_random(100, 127, 64, 127);
    for (int k = 0; k < max_words; k++) begin
      for (int ch = 0; ch < num_rows; ch += 2) begin
        wt_mem[k][ch] = -wt_mem[k][ch];   // even rows go negative
      end
    end
    run_tile(9, 4'ha);   // unknown code runs as raw
    report("clip_saturate", err0);
  endtask

  task automatic test_tile_length();
    int err0;
    err0 = errors;
    set_params(32, 64);
    load_params();
    fill_random(-8, 8, -8, 8);
    run_tile(0, 4'd1);
    if (!hung) begin
      fill_random(-8, 8, -8, 8);
      run_tile(40, 4'd1);
    end
    report("tile_length", err0);
  endtask

  task automatic test_back_to_back();
    int err0;
    err0 = errors;
    set_params(512, -150);
    load_params();
    fill_random(0, 7, 0, 7);
    run_tile(20, 4'd0);
    if (!hung) begin
      fill_random(0, 9, 0, 9);   // shorter tile must not see old sums
      run_tile(5, 4'd1);
    end
    report("back_to_back", err0);
  endtask

  initial begin
    void'($urandom(32'h1955_66de));
    errors            = 0;
    checks            = 0;
    tests_run         = 0;
    hung              = 1'b0;
    reset             = 1'b1;
    re_fm_en          = 1'b0;
    mode              = 4'd0;
    nif_mult_k_mult_k = '0;
    fm_data           = '0;
    wt_row            = '0;
    cfg_we            = 1'b0;
    cfg_addr          = '0;
    cfg_scale         = '0;
    cfg_bias          = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    tick();
    test_raw_unity();
    if (!hung) test_scaled_random();
    if (!hung) test_clip_saturate();
    if (!hung) test_tile_length();
    if (!hung) test_back_to_back();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
